/* Bender.yml */
package:
  name: hdmi_pattern

sources:
  - design/vid_pkg.sv
  - design/vid_raster_if.sv
  - design/vid_timing_gen.sv
  - design/vid_pattern_gen.sv
  - design/hdmi_pattern_top.sv
  - target: test
    files:
      - dv/hdmi_pattern_tb.sv

/* design/hdmi_pattern_top.sv */
// HDMI test-pattern source top level. Raster geometry is set by the
// parameters below; pixels leave two clocks after their raster position.
`timescale 1ns/1ps
`default_nettype none

module hdmi_pattern_top #(
  parameter int unsigned H_ACTIVE     = 1920,
  parameter int unsigned H_SYNC_START = 2008,
  parameter int unsigned H_SYNC_END   = 2052,
  parameter int unsigned H_TOTAL      = 2200,
  parameter int unsigned V_ACTIVE     = 1080,
  parameter int unsigned V_SYNC_START = 1084,
  parameter int unsigned V_SYNC_END   = 1089,
  parameter int unsigned V_TOTAL      = 1125
) (
  input  logic        sys0_clk,
  input  logic        rst_i,
  input  logic [3:0]  dipsw_i,      // Pattern select switches
  output logic [15:0] hdmi_data_o,  // Chroma upper, luma lower
  output logic        hdmi_de_o,
  output logic        hdmi_hs_o,
  output logic        hdmi_vs_o
);

  vid_raster_if raster ();

  vid_timing_gen #(
    .H_ACTIVE     (H_ACTIVE),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_ACTIVE     (V_ACTIVE),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) u_timing (
    .sys0_clk (sys0_clk),
    .rst_i    (rst_i),
    .raster_o (raster.src)
  );

  vid_pattern_gen u_pattern (
    .sys0_clk (sys0_clk),
    .rst_i    (rst_i),
    .dipsw_i  (dipsw_i),
    .raster_i (raster.dst),
    .data_o   (hdmi_data_o),
    .de_o     (hdmi_de_o),
    .hs_o     (hdmi_hs_o),
    .vs_o     (hdmi_vs_o)
  );

endmodule

`default_nettype wire

/* design/vid_pattern_gen.sv */
// Test-pattern pixel source. Picks a luma per raster position from the
// DIP switch select and delivers pixel and levels two cycles later.
`timescale 1ns/1ps
`default_nettype none

module vid_pattern_gen
  import vid_pkg::*;
(
  input  logic         sys0_clk,
  input  logic         rst_i,
  input  logic [3:0]   dipsw_i,
  vid_raster_if.dst    raster_i,
  output pixel_t       data_o,
  output logic         de_o,
  output logic         hs_o,
  output logic         vs_o
);

  pat_sel_e          sel_q;   // Synchronized switch select
  logic              box;
  logic [LUMA_W-1:0] luma;

  pixel_t pix_q;             // Pipeline stage
  logic   de_q, hs_q, vs_q;

  always_ff @(posedge sys0_clk) begin
    sel_q <= pat_sel_e'(dipsw_i);
  end

  // Overlay square in the upper left of the raster
  assign box = (raster_i.hcnt >= BOX_LO) && (raster_i.hcnt <= BOX_HI) &&
               (raster_i.vcnt >= BOX_LO) && (raster_i.vcnt <= BOX_HI);

  always_comb begin
    case (sel_q)
      PAT_H_X1:      luma = raster_i.hcnt[LUMA_W-1:0];
      PAT_V_X1:      luma = raster_i.vcnt[LUMA_W-1:0];
      PAT_H_X2:      luma = raster_i.hcnt[LUMA_W:1];
      PAT_V_X2:      luma = raster_i.vcnt[LUMA_W:1];
      PAT_H_X4:      luma = raster_i.hcnt[LUMA_W+1:2];
      PAT_V_X4:      luma = raster_i.vcnt[LUMA_W+1:2];
      PAT_H_X8:      luma = raster_i.hcnt[LUMA_W+2:3];
      PAT_V_X8:      luma = raster_i.vcnt[LUMA_W+2:3];
      PAT_BOX_V: begin
        luma = box ? raster_i.vcnt[LUMA_W-1:0] : raster_i.hcnt[LUMA_W-1:0];
      end
      PAT_BOX_FRAME: begin
        luma = box ? raster_i.fcnt[LUMA_W-1:0] : raster_i.hcnt[LUMA_W-1:0];
      end
      default:       luma = '0; // Selects 10 to 15 are black
    endcase
  end

  // Two register stages, levels travel with their pixel
  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      pix_q  <= '0;
      de_q   <= 1'b0;
      hs_q   <= 1'b0;
      vs_q   <= 1'b0;
      data_o <= '0;
      de_o   <= 1'b0;
      hs_o   <= 1'b0;
      vs_o   <= 1'b0;
    end else begin
      pix_q.chroma <= CHROMA_NEUTRAL;
      pix_q.luma   <= luma;
      de_q         <= raster_i.active;
      hs_q         <= raster_i.hsync;
      vs_q         <= raster_i.vsync;
      data_o       <= pix_q;   // Output stage
      de_o         <= de_q;
      hs_o         <= hs_q;
      vs_o         <= vs_q;
    end
  end

  // After two clean cycles the output always holds a real pixel
  a_chroma_neutral: assert property (
    @(posedge sys0_clk) disable iff (rst_i)
    !$past(rst_i, 1) && !$past(rst_i, 2) |-> data_o.chroma == CHROMA_NEUTRAL
  );

endmodule

`default_nettype wire

/* design/vid_pkg.sv */
// Shared types and constants for the HDMI test-pattern source.
// Imported by the raster interface and the two video modules.
`default_nettype none

package vid_pkg;

  // Counter geometry
  localparam int CNT_W = 12;
  typedef logic [CNT_W-1:0] cnt_t;

  // Pixel layout, chroma in the upper byte
  localparam int LUMA_W = 8;
  localparam logic [7:0] CHROMA_NEUTRAL = 8'h80;

  typedef struct packed {
    logic [7:0]        chroma;
    logic [LUMA_W-1:0] luma;
  } pixel_t;

  // DIP switch pattern codes
  typedef enum logic [3:0] {
    PAT_H_X1      = 4'd0,
    PAT_V_X1      = 4'd1,
    PAT_H_X2      = 4'd2,
    PAT_V_X2      = 4'd3,
    PAT_H_X4      = 4'd4,
    PAT_V_X4      = 4'd5,
    PAT_H_X8      = 4'd6,
    PAT_V_X8      = 4'd7,
    PAT_BOX_V     = 4'd8,   // Box follows line count
    PAT_BOX_FRAME = 4'd9    // Box follows frame count
  } pat_sel_e;

  // Square overlay bounds, inclusive on both counters
  localparam cnt_t BOX_LO = cnt_t'(128);
  localparam cnt_t BOX_HI = cnt_t'(255);

endpackage

`default_nettype wire

/* design/vid_raster_if.sv */
// Raster position and sync levels, timing generator to pattern generator.
// All six signals change together once per clock, with no handshake.
`timescale 1ns/1ps
`default_nettype none

interface vid_raster_if
  import vid_pkg::*;
();

  cnt_t hcnt;    // Pixel within line
  cnt_t vcnt;    // Line within frame
  cnt_t fcnt;    // Frame number, wraps at 4096
  logic active;
  logic hsync;
  logic vsync;

  modport src (
    output hcnt, vcnt, fcnt,
    output active, hsync, vsync
  );

  modport dst (
    input hcnt, vcnt, fcnt,
    input active, hsync, vsync
  );

endinterface

`default_nettype wire

/* design/vid_timing_gen.sv */
// Free-running raster timing: pixel, line and frame counters plus the
// active, hsync and vsync levels, all registered on the same edge.
`timescale 1ns/1ps
`default_nettype none

module vid_timing_gen
  import vid_pkg::*;
#(
  parameter int unsigned H_ACTIVE     = 1920,
  parameter int unsigned H_SYNC_START = 2008,
  parameter int unsigned H_SYNC_END   = 2052,
  parameter int unsigned H_TOTAL      = 2200,
  parameter int unsigned V_ACTIVE     = 1080,
  parameter int unsigned V_SYNC_START = 1084,
  parameter int unsigned V_SYNC_END   = 1089,
  parameter int unsigned V_TOTAL      = 1125
) (
  input  logic         sys0_clk,
  input  logic         rst_i,
  vid_raster_if.src    raster_o
);

  cnt_t hcnt_q, vcnt_q, fcnt_q;
  cnt_t hcnt_d, vcnt_d, fcnt_d;
  logic h_wrap, v_wrap;
  logic active_q, hsync_q, vsync_q;

  // Level decodes of one raster position
  function automatic logic is_active(cnt_t h, cnt_t v);
    return (h < H_ACTIVE) && (v < V_ACTIVE);
  endfunction

  function automatic logic in_span(cnt_t c, int unsigned lo, int unsigned hi);
    return (c >= lo) && (c < hi);
  endfunction

  // Next position
  always_comb begin
    h_wrap = (hcnt_q == cnt_t'(H_TOTAL - 1));
    v_wrap = (vcnt_q == cnt_t'(V_TOTAL - 1));
    hcnt_d = h_wrap ? '0 : hcnt_q + 1'b1;
    vcnt_d = vcnt_q;
    fcnt_d = fcnt_q;
    if (h_wrap) begin
      vcnt_d = v_wrap ? '0 : vcnt_q + 1'b1;
      if (v_wrap) fcnt_d = fcnt_q + 1'b1; // Modulo 4096 by width
    end
  end

  // Levels decoded from the next position so they land with the counters
  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      hcnt_q   <= '0;
      vcnt_q   <= '0;
      fcnt_q   <= '0;
      active_q <= is_active('0, '0);
      hsync_q  <= in_span('0, H_SYNC_START, H_SYNC_END);
      vsync_q  <= in_span('0, V_SYNC_START, V_SYNC_END);
    end else begin
      hcnt_q   <= hcnt_d;
      vcnt_q   <= vcnt_d;
      fcnt_q   <= fcnt_d;
      active_q <= is_active(hcnt_d, vcnt_d);
      hsync_q  <= in_span(hcnt_d, H_SYNC_START, H_SYNC_END);
      vsync_q  <= in_span(vcnt_d, V_SYNC_START, V_SYNC_END);
    end
  end

  assign raster_o.hcnt   = hcnt_q;
  assign raster_o.vcnt   = vcnt_q;
  assign raster_o.fcnt   = fcnt_q;
  assign raster_o.active = active_q;
  assign raster_o.hsync  = hsync_q;
  assign raster_o.vsync  = vsync_q;

  // Counters never leave the programmed raster
  a_hcnt_range: assert property (
    @(posedge sys0_clk) disable iff (rst_i)
    hcnt_q < H_TOTAL
  );

  a_vcnt_range: assert property (
    @(posedge sys0_clk) disable iff (rst_i)
    vcnt_q < V_TOTAL
  );

  // Sync pulse starts in blanking only
  a_hsync_in_blank: assert property (
    @(posedge sys0_clk) disable iff (rst_i)
    $rose(hsync_q) |-> !active_q
  );

endmodule

`default_nettype wire

/* dv/hdmi_pattern_tb.sv */
// Directed testbench for the HDMI test-pattern source on a small raster.
// A cycle-count model predicts position, levels and pixel for every output cycle.
`timescale 1ns/1ps
`default_nettype none

module hdmi_pattern_tb;

  localparam int H_ACT = 320;
  localparam int H_SS  = 324;
  localparam int H_SE  = 328;
  localparam int H_TOT = 340;
  localparam int V_ACT = 270;
  localparam int V_SS  = 272;
  localparam int V_SE  = 274;
  localparam int V_TOT = 276;
  localparam int FRAME_CYC = H_TOT * V_TOT;
  localparam int CLK_HALF  = 20;         // 40 ns period
  localparam int BUDGET_FRAMES = 22;     // Sum of frames over all tests
  localparam longint WATCHDOG_NS = longint'(FRAME_CYC) * BUDGET_FRAMES * 3 / 2 * (2 * CLK_HALF);

  logic        sys0_clk;
  logic        rst_i;
  logic [3:0]  dipsw_i;
  logic [15:0] hdmi_data_o;
  logic        hdmi_de_o;
  logic        hdmi_hs_o;
  logic        hdmi_vs_o;

  logic [3:0] cur_sel;  // Select latched during the last reset
  int         k_now;    // Raster position shown on the outputs, negative while flushing

  hdmi_pattern_top #(
    .H_ACTIVE     (H_ACT),
    .H_SYNC_START (H_SS),
    .H_SYNC_END   (H_SE),
    .H_TOTAL      (H_TOT),
    .V_ACTIVE     (V_ACT),
    .V_SYNC_START (V_SS),
    .V_SYNC_END   (V_SE),
    .V_TOTAL      (V_TOT)
  ) dut (
    .sys0_clk    (sys0_clk),
    .rst_i       (rst_i),
    .dipsw_i     (dipsw_i),
    .hdmi_data_o (hdmi_data_o),
    .hdmi_de_o   (hdmi_de_o),
    .hdmi_hs_o   (hdmi_hs_o),
    .hdmi_vs_o   (hdmi_vs_o)
  );

  initial begin
    sys0_clk = 1'b0;
    forever #CLK_HALF sys0_clk = ~sys0_clk;
  end

  // Four-state compare so an unknown output never matches
  task automatic expect_equal(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED test=%s %s expected=0x%0h actual=0x%0h", name, what, exp, act);
      $display("tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Expected outputs for position k_now, straight from the raster and pattern rules
  task automatic compare_pixel(input string name);
    int h, v, f, base;
    logic box;
    logic [7:0] luma;
    logic exp_de, exp_hs, exp_vs;
    if (k_now < 0) begin
      expect_equal(name, "data", 0, hdmi_data_o);
      expect_equal(name, "de", 0, hdmi_de_o);
      expect_equal(name, "hs", 0, hdmi_hs_o);
      expect_equal(name, "vs", 0, hdmi_vs_o);
    end else begin
      h = k_now % H_TOT;
      v = (k_now / H_TOT) % V_TOT;
      f = (k_now / FRAME_CYC) % 4096;
      box = (h >= 128) && (h <= 255) && (v >= 128) && (v <= 255);
      if (cur_sel < 4'd8) begin
        base = cur_sel[0] ? v : h;   // Odd selects follow the line
        luma = 8'((base >> (cur_sel >> 1)) & 'hff);
      end else if (cur_sel == 4'd8) begin
        luma = box ? 8'(v) : 8'(h);
      end else if (cur_sel == 4'd9) begin
        luma = box ? 8'(f) : 8'(h);
      end else begin
        luma = 8'h00;
      end
      exp_de = (h < H_ACT) && (v < V_ACT);
      exp_hs = (h >= H_SS) && (h < H_SE);
      exp_vs = (v >= V_SS) && (v < V_SE);
      expect_equal(name, "data", {8'h80, luma}, hdmi_data_o);
      expect_equal(name, "de", exp_de, hdmi_de_o);
      expect_equal(name, "hs", exp_hs, hdmi_hs_o);
      expect_equal(name, "vs", exp_vs, hdmi_vs_o);
    end
  endtask

  // Outputs sampled mid-cycle, away from the driving edge
  task automatic follow_model(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge sys0_clk);
      compare_pixel(name);
      @(posedge sys0_clk);
      k_now++;
    end
  endtask

  // Four reset cycles with the select applied, outputs checked while held
  task automatic apply_reset(input string name, input logic [3:0] sel);
    @(posedge sys0_clk);
    rst_i   <= 1'b1;
    dipsw_i <= sel;
    cur_sel = sel;
    k_now = -2;
    repeat (3) begin
      @(posedge sys0_clk);
      @(negedge sys0_clk);
      compare_pixel(name);
    end
    @(posedge sys0_clk);
    rst_i <= 1'b0;
    k_now = -2;
  endtask

  task automatic reset_release();
    apply_reset("reset_release", 4'd0);
    follow_model("reset_release", 2 + 2 * H_TOT);
  endtask

  task automatic raster_timing();
    int de_line, hs_line, hs_first, act_lines;
    apply_reset("raster_timing", 4'd0);
    follow_model("raster_timing", 2);
    act_lines = 0;
    for (int v = 0; v < V_TOT; v++) begin
      de_line = 0;
      hs_line = 0;
      hs_first = -1;
      for (int h = 0; h < H_TOT; h++) begin
        @(negedge sys0_clk);
        if (hdmi_de_o) de_line++;
        if (hdmi_hs_o) begin
          if (hs_first < 0) hs_first = h;
          hs_line++;
        end
        expect_equal("raster_timing", "vs", (v >= V_SS) && (v < V_SE), hdmi_vs_o);
        @(posedge sys0_clk);
        k_now++;
      end
      if (de_line > 0) act_lines++;
      expect_equal("raster_timing", "de per line", (v < V_ACT) ? H_ACT : 0, de_line);
      expect_equal("raster_timing", "hs width", H_SE - H_SS, hs_line);
      expect_equal("raster_timing", "hs start", H_SS, hs_first);
    end
    expect_equal("raster_timing", "active lines", V_ACT, act_lines);
  endtask

  task automatic gradient_sweep();
    for (int s = 0; s < 8; s++) begin
      apply_reset($sformatf("gradient_%0d", s), 4'(s));
      follow_model($sformatf("gradient_%0d", s), 2 + FRAME_CYC);
    end
  endtask

  task automatic box_overlays();
    apply_reset("box_vcnt", 4'd8);
    follow_model("box_vcnt", 2 + FRAME_CYC);
    apply_reset("box_frame", 4'd9);
    follow_model("box_frame", 2 + 3 * FRAME_CYC);  // Frame count 0, 1, 2 in the box
  endtask

  task automatic unused_selects();
    for (int s = 10; s < 16; s++) begin
      apply_reset($sformatf("unused_%0d", s), 4'(s));
      follow_model($sformatf("unused_%0d", s), 2 + FRAME_CYC);
    end
  endtask

  // Reset lands mid-frame; raster and frame count start over
  task automatic mid_frame_reset();
    apply_reset("mid_frame_reset", 4'd9);
    follow_model("mid_frame_reset", 2 + FRAME_CYC + FRAME_CYC / 2 + 37);
    apply_reset("mid_frame_reset", 4'd9);
    follow_model("mid_frame_reset", 2 + FRAME_CYC);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout: the tests did not finish within their time budget");
    $display("tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rst_i   = 1'b1;
    dipsw_i = 4'd0;
    cur_sel = 4'd0;
    k_now   = -2;
    reset_release();
    raster_timing();
    gradient_sweep();
    box_overlays();
    unused_selects();
    mid_frame_reset();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
design/vid_pkg.sv
design/vid_raster_if.sv
design/vid_timing_gen.sv
design/vid_pattern_gen.sv
design/hdmi_pattern_top.sv
dv/hdmi_pattern_tb.sv
